// File: design/linebuf_cfg_pkg.sv
package linebuf_cfg_pkg;

  // filter and image limits
  localparam int MAX_FIL = 3;
  localparam int MAX_IMG = 32;
  localparam int MAX_PAD = (MAX_FIL - 1) / 2;

  // one bank takes the incoming row while MAX_FIL banks are read
  localparam int BUF_LINE = MAX_FIL + 1;

  // counts cover the padded row plus the spare column of a small filter
  localparam int SIZE_W = $clog2(MAX_IMG + 2 * MAX_PAD + MAX_FIL);

  localparam int ADDR_W = $clog2(MAX_IMG);   // column address inside a bank

  // bank selects run 1..BUF_LINE, 0 is no bank
  localparam int LINE_W = $clog2(BUF_LINE + 1);

  localparam int PIX_W = 16;

  localparam int CTRL_DELAY = 1;   // memory read latency

endpackage

// File: design/linebuf_types_pkg.sv
package linebuf_types_pkg;

  import linebuf_cfg_pkg::*;

  typedef logic [PIX_W-1:0] pixel_t;

  typedef logic [SIZE_W-1:0] size_t;   // image, column and row counts

  typedef logic [MAX_FIL-1:0] row_mask_t;   // one bit per window row

  // request parameters held for one image
  typedef struct packed {
    size_t img;
    size_t fil;
    size_t pad;
  } cfg_t;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;     // shared by write and reads
    logic [LINE_W-1:0] wsel;
    logic [LINE_W-1:0] rsel;     // bank of window row 0
    row_mask_t         row_en;
  } mem_ctrl_t;

  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } mark_t;

  // index is the window row
  typedef pixel_t [MAX_FIL-1:0] column_t;

  // [row][col], col MAX_FIL-1 holds the newest column
  typedef pixel_t [MAX_FIL-1:0][MAX_FIL-1:0] window_t;

endpackage

// File: design/pipe_delay.sv
module pipe_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     xrst,
  input  payload_t din,
  output payload_t dout
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[DEPTH-1];

endmodule

// File: design/line_mem.sv
module line_mem (
  input  logic                          clk,
  input  logic                          xrst,
  input  linebuf_types_pkg::mem_ctrl_t  ctrl,
  input  linebuf_types_pkg::pixel_t     pixel,
  output linebuf_types_pkg::column_t    col,
  output linebuf_types_pkg::row_mask_t  row_en
);

  import linebuf_cfg_pkg::*;
  import linebuf_types_pkg::*;

  pixel_t bank [BUF_LINE][MAX_IMG];

  // array index of the bank k steps on from select code sel
  function automatic int bank_of(input logic [LINE_W-1:0] sel, input int k);
    int s;
    s = (int'(sel) - 1 + k) % BUF_LINE;
    if (s < 0)
      s = s + BUF_LINE;
    return s;
  endfunction

  always_ff @(posedge clk) begin
    if (ctrl.we && ctrl.wsel != '0) begin
      bank[bank_of(ctrl.wsel, 0)][ctrl.addr] <= pixel;
    end
  end

  // same column from MAX_FIL consecutive banks
  always_ff @(posedge clk) begin
    for (int k = 0; k < MAX_FIL; k++) begin
      col[k] <= bank[bank_of(ctrl.rsel, k)][ctrl.addr];
    end
  end

  pipe_delay #(
    .payload_t (row_mask_t),
    .DEPTH     (CTRL_DELAY)
  ) row_dly (
    .clk  (clk),
    .xrst (xrst),
    .din  (ctrl.row_en),
    .dout (row_en)
  );

endmodule

// File: design/window_shift.sv
module window_shift (
  input  logic                          clk,
  input  logic                          xrst,
  input  linebuf_types_pkg::column_t    col,
  input  linebuf_types_pkg::row_mask_t  row_en,
  input  linebuf_types_pkg::mark_t      mark_in,
  output linebuf_types_pkg::window_t    win,
  output linebuf_types_pkg::mark_t      mark
);

  import linebuf_cfg_pkg::*;
  import linebuf_types_pkg::*;

  column_t col_m;

  // masked rows and pad columns come in as zeros
  always_comb begin
    for (int k = 0; k < MAX_FIL; k++) begin
      col_m[k] = row_en[k] ? col[k] : '0;
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < MAX_FIL; k++) begin
      for (int m = 0; m < MAX_FIL - 1; m++) begin
        win[k][m] <= win[k][m+1];   // older columns move left
      end
      win[k][MAX_FIL-1] <= col_m[k];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mark <= '0;
    end else begin
      mark <= mark_in;   // same edge as the window
    end
  end

endmodule

// File: design/linebuf_ctrl.sv
module linebuf_ctrl (
  input  logic                          clk,
  input  logic                          xrst,
  input  linebuf_types_pkg::size_t      img_size,
  input  linebuf_types_pkg::size_t      fil_size,
  input  linebuf_types_pkg::size_t      pad_size,
  input  logic                          req,
  output logic                          ack,
  output logic                          ready,
  output linebuf_types_pkg::mem_ctrl_t  mem_ctrl,
  output linebuf_types_pkg::mark_t      mark
);

  import linebuf_cfg_pkg::*;
  import linebuf_types_pkg::*;

  typedef enum logic [1:0] {
    S_WAIT,
    S_CHARGE,
    S_ACTIVE
  } state_t;

  state_t            state;
  cfg_t              cfg;
  logic [2:0]        ack_sr;
  logic              take;
  size_t             col_cnt;
  size_t             row_cnt;
  logic [LINE_W-1:0] bank_cnt;   // bank of the row being written, from 0
  size_t             offs;
  size_t             lag;
  size_t             width;
  logic              col_last;
  logic              charge_end;
  logic              active_end;
  logic              done;
  logic              real_col;
  row_mask_t         row_mask;

  // bank code holding the row `back` rows before the written one
  function automatic logic [LINE_W-1:0] read_sel(input logic [LINE_W-1:0] bank,
                                                 input size_t back);
    int s;
    s = (int'(bank) - int'(back)) % BUF_LINE;
    if (s < 0)
      s = s + BUF_LINE;
    return LINE_W'(s + 1);
  endfunction

  // a small filter sits centred in the window
  assign offs  = size_t'((MAX_FIL - int'(cfg.fil)) / 2);
  assign lag   = size_t'(MAX_FIL - 1) - offs;   // columns before the first window
  assign width = cfg.img + (cfg.pad << 1) + size_t'(MAX_FIL) - cfg.fil - offs;

  assign col_last   = col_cnt == width - 1'b1;
  assign charge_end = state == S_CHARGE && row_cnt == cfg.fil - cfg.pad - 1'b1 && col_last;
  assign active_end = state == S_ACTIVE && row_cnt == cfg.img + cfg.pad && col_last;

  assign take = state == S_WAIT && req && ack;
  assign ack  = state == S_WAIT && ack_sr[2];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT:   if (take) state <= S_CHARGE;
        S_CHARGE: if (charge_end) state <= S_ACTIVE;
        S_ACTIVE: if (active_end) state <= S_WAIT;
        default:  state <= S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      cfg <= '0;
    end else if (take) begin
      cfg <= '{img: img_size, fil: fil_size, pad: pad_size};
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack_sr <= '0;
    end else begin
      ack_sr <= {ack_sr[1:0], state == S_WAIT};   // idle for 3 cycles
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col_cnt  <= '0;
      row_cnt  <= '0;
      bank_cnt <= '0;
    end else if (state == S_WAIT || active_end) begin
      col_cnt  <= '0;
      row_cnt  <= '0;
      bank_cnt <= '0;
    end else if (col_last) begin
      col_cnt  <= '0;
      row_cnt  <= row_cnt + 1'b1;
      bank_cnt <= (bank_cnt == LINE_W'(BUF_LINE - 1)) ? '0 : bank_cnt + 1'b1;
    end else begin
      col_cnt <= col_cnt + 1'b1;
    end
  end

  assign real_col = col_cnt >= cfg.pad && col_cnt < cfg.img + cfg.pad;
  assign ready    = state != S_WAIT && row_cnt < cfg.img && real_col;

  // window row k reads image row row_cnt - fil - offs + k
  always_comb begin
    for (int k = 0; k < MAX_FIL; k++) begin
      row_mask[k] = real_col
                 && size_t'(k) >= offs
                 && size_t'(k) < offs + cfg.fil
                 && row_cnt + size_t'(k) >= cfg.fil + offs
                 && row_cnt + size_t'(k) < cfg.img + cfg.fil + offs;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_ctrl <= '0;
    end else if (state == S_WAIT) begin
      mem_ctrl <= '0;
    end else begin
      mem_ctrl.we     <= ready;   // pixel lands on this cycle
      mem_ctrl.addr   <= ADDR_W'(col_cnt - cfg.pad);
      mem_ctrl.wsel   <= bank_cnt + 1'b1;
      mem_ctrl.rsel   <= read_sel(bank_cnt, cfg.fil + offs);
      mem_ctrl.row_en <= row_mask;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      done <= 1'b0;
      mark <= '0;
    end else begin
      done       <= active_end;
      mark.start <= state == S_ACTIVE && row_cnt == cfg.fil - cfg.pad && col_cnt == lag;
      mark.valid <= state == S_ACTIVE && col_cnt >= lag;
      mark.stop  <= done;   // one cycle past the last window
    end
  end

endmodule

// File: design/linebuf_pad_top.sv
module linebuf_pad_top (
  input  logic                        clk,
  input  logic                        xrst,
  input  linebuf_types_pkg::size_t    img_size,
  input  linebuf_types_pkg::size_t    fil_size,
  input  linebuf_types_pkg::size_t    pad_size,
  input  logic                        req,
  input  linebuf_types_pkg::pixel_t   pixel,
  output logic                        ack,
  output logic                        ready,
  output linebuf_types_pkg::window_t  win,
  output logic                        start,
  output logic                        valid,
  output logic                        stop
);

  import linebuf_cfg_pkg::*;
  import linebuf_types_pkg::*;

  mem_ctrl_t mem_ctrl;
  mark_t     ctrl_mark;
  mark_t     line_mark;   // aligned with the memory read
  mark_t     win_mark;
  column_t   col;
  row_mask_t row_en;

  linebuf_ctrl ctrl_unit (
    .clk      (clk),
    .xrst     (xrst),
    .img_size (img_size),
    .fil_size (fil_size),
    .pad_size (pad_size),
    .req      (req),
    .ack      (ack),
    .ready    (ready),
    .mem_ctrl (mem_ctrl),
    .mark     (ctrl_mark)
  );

  pipe_delay #(
    .payload_t (mark_t),
    .DEPTH     (CTRL_DELAY)
  ) mark_dly (
    .clk  (clk),
    .xrst (xrst),
    .din  (ctrl_mark),
    .dout (line_mark)
  );

  line_mem line_buf (
    .clk    (clk),
    .xrst   (xrst),
    .ctrl   (mem_ctrl),
    .pixel  (pixel),
    .col    (col),
    .row_en (row_en)
  );

  window_shift win_shift (
    .clk     (clk),
    .xrst    (xrst),
    .col     (col),
    .row_en  (row_en),
    .mark_in (line_mark),
    .win     (win),
    .mark    (win_mark)
  );

  assign start = win_mark.start;
  assign valid = win_mark.valid;
  assign stop  = win_mark.stop;

endmodule

// File: sim/linebuf_pad_chk.sv
module linebuf_pad_chk (
  input  logic                        clk,
  input  logic                        xrst,
  input  linebuf_types_pkg::size_t    img_size,
  input  linebuf_types_pkg::size_t    fil_size,
  input  linebuf_types_pkg::size_t    pad_size,
  input  logic                        req,
  input  logic                        ack,
  input  logic                        ready,
  input  linebuf_types_pkg::window_t  win,
  input  logic                        start,
  input  logic                        valid,
  input  logic                        stop
);
  timeunit 1ns;
  timeprecision 100ps;

  import linebuf_cfg_pkg::*;
  import linebuf_types_pkg::*;

  cfg_t cfg;          // sizes of the image in flight
  logic busy;
  logic seen_req;
  logic started;
  int   idle_cnt;
  int   win_cnt;
  int   wrow;
  int   wcol;
  int   n_side;
  int   fail_cnt = 0;

  // every tap of the filter against the encoded image, zero outside it
  function automatic logic window_match(input window_t w, input int wr, input int wc,
                                        input int img, input int fil, input int pad);
    int     offs;
    int     r;
    int     c;
    pixel_t want;
    logic   ok;
    ok   = 1'b1;
    offs = (MAX_FIL - fil) / 2;   // a 1-tap filter sits in the centre
    for (int i = 0; i < fil; i++) begin
      for (int j = 0; j < fil; j++) begin
        r = wr + i - pad;
        c = wc + j - pad;
        if (r < 0 || r >= img || c < 0 || c >= img)
          want = '0;
        else
          want = pixel_t'(r * 64 + c + 1);
        if (w[offs+i][offs+j] !== want)
          ok = 1'b0;
      end
    end
    return ok;
  endfunction

  assign n_side = int'(cfg.img) + 2 * int'(cfg.pad) - int'(cfg.fil) + 1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      cfg      <= '0;
      busy     <= 1'b0;
      seen_req <= 1'b0;
      started  <= 1'b0;
      idle_cnt <= 0;
      win_cnt  <= 0;
      wrow     <= 0;
      wcol     <= 0;
    end else begin
      if (req && ack) begin
        cfg      <= '{img: img_size, fil: fil_size, pad: pad_size};
        busy     <= 1'b1;
        seen_req <= 1'b1;
        started  <= 1'b0;
        win_cnt  <= 0;
        wrow     <= 0;
        wcol     <= 0;
      end else if (stop) begin
        busy <= 1'b0;
      end
      if (start)
        started <= 1'b1;
      if (valid) begin
        win_cnt <= win_cnt + 1;
        if (wcol == n_side - 1) begin   // next window row
          wcol <= 0;
          wrow <= wrow + 1;
        end else begin
          wcol <= wcol + 1;
        end
      end
      idle_cnt <= busy ? 0 : (idle_cnt < 7 ? idle_cnt + 1 : idle_cnt);
    end
  end

  a_idle_quiet: assert property (@(posedge clk) disable iff (!xrst)
      !busy |-> !ready && !start && !valid && !stop)
    else begin
      fail_cnt++;
      $error("ready or a marker is active with no image in progress");
    end

  a_ack_late: assert property (@(posedge clk) disable iff (!xrst)
      !seen_req && idle_cnt < 3 |-> !ack)
    else begin
      fail_cnt++;
      $error("ack rose too early after reset");
    end

  a_ack_back: assert property (@(posedge clk) disable iff (!xrst)
      !busy && idle_cnt == 3 |-> ack)
    else begin
      fail_cnt++;
      $error("ack did not return 3 cycles after idle");
    end

  a_ack_busy: assert property (@(posedge clk) disable iff (!xrst)
      busy && !stop |-> !ack)
    else begin
      fail_cnt++;
      $error("ack is high while an image is in progress");
    end

  a_start_first: assert property (@(posedge clk) disable iff (!xrst)
      (start |-> valid && win_cnt == 0 && !started) and (valid && win_cnt == 0 |-> start))
    else begin
      fail_cnt++;
      $error("start does not mark the first window, window count %0d", win_cnt);
    end

  a_win_count: assert property (@(posedge clk) disable iff (!xrst)
      (valid |-> win_cnt < n_side * n_side)
      and (stop |-> started && !valid && win_cnt == n_side * n_side))
    else begin
      fail_cnt++;
      $error("Error window count expected %0d actual %0d", n_side * n_side, win_cnt);
    end

  a_win_data: assert property (@(posedge clk) disable iff (!xrst)
      valid |-> window_match(win, wrow, wcol, int'(cfg.img), int'(cfg.fil), int'(cfg.pad)))
    else begin
      fail_cnt++;
      $error("Error window (%0d,%0d) differs from the padded image", wrow, wcol);
    end

endmodule

// File: sim/tb_linebuf_pad.sv
module tb_linebuf_pad;
  timeunit 1ns;
  timeprecision 100ps;

  import linebuf_types_pkg::*;

  localparam int WAIT_LIMIT = 5000;

  logic        clk;
  logic        xrst;
  size_t       img_size;
  size_t       fil_size;
  size_t       pad_size;
  logic        req;
  pixel_t      pixel = '0;
  logic        ack;
  logic        ready;
  window_t     win;
  logic        start;
  logic        valid;
  logic        stop;
  int          src_img;
  int          pix_cnt;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;
  logic [31:0] lfsr = 32'hec4b0fd9;
  int          rand_img;

  linebuf_pad_top uut (
    .clk      (clk),
    .xrst     (xrst),
    .img_size (img_size),
    .fil_size (fil_size),
    .pad_size (pad_size),
    .req      (req),
    .pixel    (pixel),
    .ack      (ack),
    .ready    (ready),
    .win      (win),
    .start    (start),
    .valid    (valid),
    .stop     (stop)
  );

  bind linebuf_pad_top linebuf_pad_chk chk (
    .clk      (clk),
    .xrst     (xrst),
    .img_size (img_size),
    .fil_size (fil_size),
    .pad_size (pad_size),
    .req      (req),
    .ack      (ack),
    .ready    (ready),
    .win      (win),
    .start    (start),
    .valid    (valid),
    .stop     (stop)
  );

  function automatic pixel_t pixel_code(input int row, input int col);
    return pixel_t'(row * 64 + col + 1);
  endfunction

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int count, output int value);
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // pixel source, one pixel on the cycle after each ready
  always @(posedge clk) begin
    if (!xrst) begin
      pix_cnt <= 0;
      src_img <= 1;
    end else if (req && ack) begin
      pix_cnt <= 0;
      src_img <= int'(img_size);
    end else if (ready) begin
      pixel   <= pixel_code(pix_cnt / src_img, pix_cnt % src_img);
      pix_cnt <= pix_cnt + 1;
    end
  end

  task automatic wait_for(input string what, output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
      case (what)
        "ack":   ok = ack;
        "start": ok = start;
        default: ok = stop;
      endcase
    end
  endtask

  task automatic report(input string name, input int errs_before, input bit ok,
                        input string what);
    int errs;
    errs = uut.chk.fail_cnt - errs_before;
    tests_run++;
    if (!ok) begin
      tests_failed++;
      timed_out = 1'b1;
      $display("test %s failed: %s never came within %0d cycles", name, what, WAIT_LIMIT);
    end else if (errs != 0) begin
      tests_failed++;
      $display("Error test %s: assertion failures expected 0, actual %0d", name, errs);
    end else begin
      $display("test %s passed", name);
    end
  endtask

  task automatic run_image(input string name, input int img, input int fil, input int pad,
                           input bit poke);
    int    errs_before;
    bit    ok;
    string what;
    if (!timed_out) begin
      errs_before = uut.chk.fail_cnt;
      what = "ack";
      wait_for(what, ok);
      if (ok) begin
        img_size <= size_t'(img);
        fil_size <= size_t'(fil);
        pad_size <= size_t'(pad);
        req      <= 1'b1;
        @(posedge clk);
        req  <= 1'b0;
        what = "start";
        wait_for(what, ok);
      end
      if (ok && poke) begin
        img_size <= size_t'(2);   // must not reach the DUT, ack is low
        req      <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
      end
      if (ok) begin
        what = "stop";
        wait_for(what, ok);
      end
      if (ok) begin
        what = "ack";
        wait_for(what, ok);
      end
      report(name, errs_before, ok, what);
    end
  endtask

  initial begin
    int errs_before;
    bit ok;
    xrst         = 1'b0;
    req          = 1'b0;
    img_size     = '0;
    fil_size     = '0;
    pad_size     = '0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    repeat (8) @(posedge clk);
    xrst <= 1'b1;
    errs_before = uut.chk.fail_cnt;
    wait_for("ack", ok);
    report("reset_idle", errs_before, ok, "ack");
    run_image("pad1_fil3", 8, 3, 1, 1'b0);
    run_image("pad0_fil3", 8, 3, 0, 1'b0);
    run_image("fil1", 6, 1, 0, 1'b0);
    random_bits(5, rand_img);
    rand_img = 4 + rand_img % 29;
    run_image("random_size", rand_img, 3, 1, 1'b0);
    run_image("req_while_busy", 5, 3, 1, 1'b1);
    $display("tests run %0d, failed %0d, assertion failures %0d",
             tests_run, tests_failed, uut.chk.fail_cnt);
    if (tests_failed == 0 && uut.chk.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: linebuf_pad_top.f
design/linebuf_cfg_pkg.sv
design/linebuf_types_pkg.sv
design/pipe_delay.sv
design/line_mem.sv
design/window_shift.sv
design/linebuf_ctrl.sv
design/linebuf_pad_top.sv
sim/linebuf_pad_chk.sv
sim/tb_linebuf_pad.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_linebuf_pad -f linebuf_pad_top.f -o sim_linebuf_pad

./obj_dir/sim_linebuf_pad +verilator+error+limit+1000 | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
